// File: Bender.yml
package:
  name: pwr_domain_ctrl

sources:
  - verilog/pwr_pkg.sv
  - verilog/pwr_wait_timer.sv
  - verilog/pwr_switch_chain.sv
  - verilog/pwr_seq_fsm.sv
  - verilog/pwr_domain_ctrl.sv
  - target: test
    files:
      - tb/tb_pwr_domain_ctrl.sv

// File: pwr_domain_ctrl.f
verilog/pwr_pkg.sv
verilog/pwr_wait_timer.sv
verilog/pwr_switch_chain.sv
verilog/pwr_seq_fsm.sv
verilog/pwr_domain_ctrl.sv
tb/tb_pwr_domain_ctrl.sv

// File: tb/tb_pwr_domain_ctrl.sv
// Testbench for the power domain controller
// Directed sequences, ignored commands and an LFSR-driven random run

`timescale 1ns/100ps

module tb_pwr_domain_ctrl;

  localparam int unsigned ACK_LATENCY = 15;
  localparam int unsigned RST_HOLD    = 4;
  localparam int unsigned ISO_SETUP   = 2;
  localparam int SEQ_LIMIT = ACK_LATENCY + RST_HOLD + 2 * ISO_SETUP + 10;
  localparam int N_CMDS    = 52;
  localparam int WD_CYCLES = N_CMDS * SEQ_LIMIT + 100;

  logic clk_i;
  logic rst_n_i;
  logic cmd_valid_i;
  pwr_pkg::pwr_cmd_e cmd_i;
  logic sw_on_o, sw_ack_o, iso_o, dom_rst_n_o, ret_o, busy_o, done_o;
  pwr_pkg::pwr_state_e state_o;

  int errors;
  int cyc;
  logic [15:0] lfsr;
  pwr_pkg::pwr_state_e ref_state;
  // Cycle of the latest edge seen on each control
  int t_sw_on_r, t_sw_on_f, t_sw_ack_r, t_sw_ack_f, t_rst_r, t_rst_f;
  int t_iso_r, t_iso_f, t_ret_r, t_ret_f, t_done;
  logic p_sw_on, p_sw_ack, p_rst, p_iso, p_ret;

  pwr_domain_ctrl #(
    .ACK_LATENCY (ACK_LATENCY),
    .RST_HOLD    (RST_HOLD),
    .ISO_SETUP   (ISO_SETUP)
  ) dut0 (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .cmd_valid_i (cmd_valid_i),
    .cmd_i       (cmd_i),
    .sw_on_o     (sw_on_o),
    .sw_ack_o    (sw_ack_o),
    .iso_o       (iso_o),
    .dom_rst_n_o (dom_rst_n_o),
    .ret_o       (ret_o),
    .busy_o      (busy_o),
    .done_o      (done_o),
    .state_o     (state_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  // Edge recorder and safety monitor
  always @(negedge clk_i) begin
    cyc = cyc + 1;
    if (sw_on_o && !p_sw_on) t_sw_on_r = cyc;
    if (!sw_on_o && p_sw_on) t_sw_on_f = cyc;
    if (sw_ack_o && !p_sw_ack) t_sw_ack_r = cyc;
    if (!sw_ack_o && p_sw_ack) t_sw_ack_f = cyc;
    if (dom_rst_n_o && !p_rst) t_rst_r = cyc;
    if (!dom_rst_n_o && p_rst) t_rst_f = cyc;
    if (iso_o && !p_iso) t_iso_r = cyc;
    if (!iso_o && p_iso) t_iso_f = cyc;
    if (ret_o && !p_ret) t_ret_r = cyc;
    if (!ret_o && p_ret) t_ret_f = cyc;
    if (done_o) t_done = cyc;
    {p_sw_on, p_sw_ack, p_rst, p_iso, p_ret} = {sw_on_o, sw_ack_o, dom_rst_n_o, iso_o, ret_o};
    if (rst_n_i) begin
      assert (!dom_rst_n_o || sw_ack_o) else begin
        $display("Error at %0t: domain reset released without switch acknowledge", $time);
        errors++;
      end
      assert (iso_o || dom_rst_n_o) else begin
        $display("Error at %0t: isolation dropped while domain held in reset", $time);
        errors++;
      end
      assert (!ret_o || iso_o) else begin
        $display("Error at %0t: retention active without isolation", $time);
        errors++;
      end
    end
  end

  initial begin
    repeat (WD_CYCLES) @(posedge clk_i);
    $display("Error: watchdog expired after %0d cycles, errors so far %0d", WD_CYCLES, errors);
    $display("SOME TESTS FAILED");
    $finish;
  end

  // 16-bit Galois LFSR, one step per bit
  function automatic logic [15:0] lfsr_step(logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic rand_bits(input int n, output int val);
    val = 0;
    for (int i = 0; i < n; i++) begin
      val = (val << 1) | lfsr[0];
      lfsr = lfsr_step(lfsr);
    end
  endtask

  // Stable state reached from a stable state, itself if the command is illegal
  function automatic pwr_pkg::pwr_state_e next_state(pwr_pkg::pwr_state_e st,
                                                     pwr_pkg::pwr_cmd_e cmd);
    if (st == pwr_pkg::ST_OFF && cmd == pwr_pkg::CMD_ON) return pwr_pkg::ST_ON;
    if (st == pwr_pkg::ST_ON && cmd == pwr_pkg::CMD_OFF) return pwr_pkg::ST_OFF;
    if (st == pwr_pkg::ST_ON && cmd == pwr_pkg::CMD_RETAIN) return pwr_pkg::ST_RET;
    if (st == pwr_pkg::ST_RET && cmd == pwr_pkg::CMD_ON) return pwr_pkg::ST_ON;
    if (st == pwr_pkg::ST_RET && cmd == pwr_pkg::CMD_OFF) return pwr_pkg::ST_OFF;
    return st;
  endfunction

  task automatic check_val(input string name, input int got, input int exp);
    assert (got == exp) else begin
      $display("FAIL at %0t: %s got %0d expected %0d", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_order(input string what, input int first, input int second);
    assert (first < second) else begin
      $display("Error at %0t: %s out of order (%0d vs %0d)", $time, what, first, second);
      errors++;
    end
  endtask

  // Outputs of a stable state: sw_on, sw_ack, iso, dom_rst_n, ret
  task automatic check_stable(input pwr_pkg::pwr_state_e st);
    logic [4:0] exp;
    case (st)
      pwr_pkg::ST_ON:  exp = 5'b11010;
      pwr_pkg::ST_RET: exp = 5'b11111;
      default:         exp = 5'b00100;
    endcase
    check_val("state_o", state_o, st);
    check_val("sw_on_o", sw_on_o, exp[4]);
    check_val("sw_ack_o", sw_ack_o, exp[3]);
    check_val("iso_o", iso_o, exp[2]);
    check_val("dom_rst_n_o", dom_rst_n_o, exp[1]);
    check_val("ret_o", ret_o, exp[0]);
  endtask

  task automatic send_cmd(input pwr_pkg::pwr_cmd_e cmd);
    @(negedge clk_i);
    cmd_valid_i = 1'b1;
    cmd_i = cmd;
    @(negedge clk_i);
    cmd_valid_i = 1'b0;
  endtask

  // Legal command, optionally followed by one sent while busy
  task automatic run_cmd(input pwr_pkg::pwr_cmd_e cmd, input logic mid_en,
                         input pwr_pkg::pwr_cmd_e mid_cmd);
    int n;
    send_cmd(cmd);
    check_val("busy_o", busy_o, 1);
    n = 0;
    if (mid_en) begin
      cmd_valid_i = 1'b1;
      cmd_i = mid_cmd;
    end
    while (!done_o && n < SEQ_LIMIT) begin
      @(negedge clk_i);
      cmd_valid_i = 1'b0;
      n++;
    end
    // Strobe again in the done cycle, where the state is already stable
    cmd_valid_i = mid_en;
    assert (done_o) else begin
      $display("Error at %0t: no done_o within %0d cycles", $time, SEQ_LIMIT);
      errors++;
    end
    ref_state = next_state(ref_state, cmd);
    check_val("busy_o", busy_o, 1);
    @(negedge clk_i);
    cmd_valid_i = 1'b0;
    check_val("busy_o", busy_o, 0);
    check_val("done_o", done_o, 0);
    check_stable(ref_state);
  endtask

  task automatic try_ignored(input pwr_pkg::pwr_cmd_e cmd);
    send_cmd(cmd);
    repeat (3) begin
      check_val("busy_o", busy_o, 0);
      check_val("done_o", done_o, 0);
      check_stable(ref_state);
      @(negedge clk_i);
    end
  endtask

  task automatic test_reset();
    check_stable(pwr_pkg::ST_OFF);
    check_val("busy_o", busy_o, 0);
    check_val("done_o", done_o, 0);
  endtask

  task automatic test_power_up();
    run_cmd(pwr_pkg::CMD_ON, 1'b0, pwr_pkg::CMD_NOP);
    check_order("sw_on rise / sw_ack rise", t_sw_on_r, t_sw_ack_r);
    check_order("sw_ack rise / reset release", t_sw_ack_r, t_rst_r);
    check_order("reset release / iso fall", t_rst_r, t_iso_f);
    check_val("sw_ack_o latency", t_sw_ack_r - t_sw_on_r, ACK_LATENCY);
    check_val("done_o cycle", t_done, t_iso_f);
  endtask

  task automatic test_power_down();
    run_cmd(pwr_pkg::CMD_OFF, 1'b0, pwr_pkg::CMD_NOP);
    check_order("iso rise / reset assert", t_iso_r, t_rst_f);
    check_order("reset assert / sw_on fall", t_rst_f, t_sw_on_f);
    check_order("sw_on fall / sw_ack fall", t_sw_on_f, t_sw_ack_f);
    check_val("done_o cycle", t_done, t_sw_ack_f + 1);
  endtask

  task automatic test_retention();
    int sw_f;
    int rst_f;
    run_cmd(pwr_pkg::CMD_ON, 1'b0, pwr_pkg::CMD_NOP);
    sw_f = t_sw_on_f;
    rst_f = t_rst_f;
    run_cmd(pwr_pkg::CMD_RETAIN, 1'b0, pwr_pkg::CMD_NOP);
    check_order("iso rise / ret rise", t_iso_r, t_ret_r);
    check_val("sw_on_o falls", t_sw_on_f, sw_f);
    check_val("dom_rst_n_o falls", t_rst_f, rst_f);
    run_cmd(pwr_pkg::CMD_ON, 1'b0, pwr_pkg::CMD_NOP);
    check_order("ret fall / iso fall", t_ret_f, t_iso_f);
    run_cmd(pwr_pkg::CMD_RETAIN, 1'b0, pwr_pkg::CMD_NOP);
    run_cmd(pwr_pkg::CMD_OFF, 1'b0, pwr_pkg::CMD_NOP);
    check_order("ret fall / reset assert", t_ret_f, t_rst_f);
  endtask

  task automatic test_ignored();
    try_ignored(pwr_pkg::CMD_RETAIN);
    try_ignored(pwr_pkg::CMD_OFF);
    run_cmd(pwr_pkg::CMD_ON, 1'b1, pwr_pkg::CMD_OFF);
    try_ignored(pwr_pkg::CMD_ON);
    run_cmd(pwr_pkg::CMD_OFF, 1'b1, pwr_pkg::CMD_ON);
  endtask

  task automatic test_random();
    int cmd;
    int gap;
    int mid;
    int mid_cmd;
    for (int i = 0; i < 40; i++) begin
      rand_bits(2, cmd);
      rand_bits(3, gap);
      rand_bits(1, mid);
      rand_bits(2, mid_cmd);
      repeat (gap) @(negedge clk_i);
      if (next_state(ref_state, pwr_pkg::pwr_cmd_e'(cmd)) != ref_state) begin
        run_cmd(pwr_pkg::pwr_cmd_e'(cmd), mid[0], pwr_pkg::pwr_cmd_e'(mid_cmd));
      end else begin
        try_ignored(pwr_pkg::pwr_cmd_e'(cmd));
      end
    end
    check_stable(ref_state);
  endtask

  initial begin
    errors = 0;
    cyc = 0;
    lfsr = 16'd62963;
    ref_state = pwr_pkg::ST_OFF;
    {t_sw_on_r, t_sw_on_f, t_sw_ack_r, t_sw_ack_f, t_rst_r, t_rst_f} = '0;
    {t_iso_r, t_iso_f, t_ret_r, t_ret_f, t_done} = '0;
    {p_sw_on, p_sw_ack, p_rst, p_iso, p_ret} = 5'b00100;
    rst_n_i = 1'b0;
    cmd_valid_i = 1'b0;
    cmd_i = pwr_pkg::CMD_NOP;
    repeat (5) @(negedge clk_i);
    rst_n_i = 1'b1;
    @(negedge clk_i);
    test_reset();
    test_power_up();
    test_power_down();
    test_retention();
    test_ignored();
    test_random();
    $display("Checks done: %0d errors", errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: verilog/pwr_domain_ctrl.sv
// Power domain controller top level
// Sequencer, wait timer and switch cell model for one gated domain

`timescale 1ns/100ps

module pwr_domain_ctrl #(
  parameter int unsigned ACK_LATENCY = 15,
  parameter int unsigned RST_HOLD    = 4,
  parameter int unsigned ISO_SETUP   = 2
) (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                cmd_valid_i,
  input  pwr_pkg::pwr_cmd_e   cmd_i,
  output logic                sw_on_o,
  output logic                sw_ack_o,
  output logic                iso_o,
  output logic                dom_rst_n_o,
  output logic                ret_o,
  output logic                busy_o,
  output logic                done_o,
  output pwr_pkg::pwr_state_e state_o
);

  logic                        sw_on;
  logic                        sw_ack;
  logic                        tmr_load;
  logic [pwr_pkg::TIMER_W-1:0] tmr_count;
  logic                        tmr_done;

  pwr_seq_fsm #(
    .RST_HOLD  (RST_HOLD),
    .ISO_SETUP (ISO_SETUP)
  ) pwr_seq_fsm_i (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .cmd_valid_i (cmd_valid_i),
    .cmd_i       (cmd_i),
    .sw_ack_i    (sw_ack),
    .tmr_done_i  (tmr_done),
    .tmr_load_o  (tmr_load),
    .tmr_count_o (tmr_count),
    .sw_on_o     (sw_on),
    .iso_o       (iso_o),
    .dom_rst_n_o (dom_rst_n_o),
    .ret_o       (ret_o),
    .busy_o      (busy_o),
    .done_o      (done_o),
    .state_o     (state_o)
  );

  pwr_wait_timer pwr_wait_timer_i (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .load_i  (tmr_load),
    .count_i (tmr_count),
    .done_o  (tmr_done)
  );

  // Stands in for the physical switch cells
  pwr_switch_chain #(
    .ACK_LATENCY (ACK_LATENCY)
  ) pwr_switch_chain_i (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .sw_on_i  (sw_on),
    .sw_ack_o (sw_ack)
  );

  assign sw_on_o  = sw_on;
  assign sw_ack_o = sw_ack;

endmodule

// File: verilog/pwr_pkg.sv
// Power domain sequencer definitions
// Host command opcodes, sequencer states and the wait timer width

package pwr_pkg;

  // Wait timer count width
  localparam int unsigned TIMER_W = 8;

  // Host command strobed with cmd_valid_i
  typedef enum logic [1:0] {
    CMD_NOP    = 2'd0,
    CMD_ON     = 2'd1,
    CMD_OFF    = 2'd2,
    CMD_RETAIN = 2'd3
  } pwr_cmd_e;

  // Sequencer state
  typedef enum logic [3:0] {
    // Stable
    ST_OFF       = 4'd0,
    ST_ON        = 4'd1,
    ST_RET       = 4'd2,
    // Power-up
    ST_UP_SW     = 4'd3,
    ST_UP_RST    = 4'd4,
    // Power-down
    ST_DN_ISO    = 4'd5,
    ST_DN_SW     = 4'd6,
    // Retention
    ST_RET_ENTER = 4'd7,
    ST_RET_EXIT  = 4'd8
  } pwr_state_e;

endpackage

// File: verilog/pwr_seq_fsm.sv
// Power-gating sequencer FSM
// Orders switch, isolation, domain reset and retention for one domain

`timescale 1ns/100ps

module pwr_seq_fsm #(
  parameter int unsigned RST_HOLD  = 4,
  parameter int unsigned ISO_SETUP = 2
) (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  logic                        cmd_valid_i,
  input  pwr_pkg::pwr_cmd_e           cmd_i,
  input  logic                        sw_ack_i,
  input  logic                        tmr_done_i,
  output logic                        tmr_load_o,
  output logic [pwr_pkg::TIMER_W-1:0] tmr_count_o,
  output logic                        sw_on_o,
  output logic                        iso_o,
  output logic                        dom_rst_n_o,
  output logic                        ret_o,
  output logic                        busy_o,
  output logic                        done_o,
  output pwr_pkg::pwr_state_e         state_o
);

  localparam logic [pwr_pkg::TIMER_W-1:0] RST_CNT = RST_HOLD[pwr_pkg::TIMER_W-1:0];
  localparam logic [pwr_pkg::TIMER_W-1:0] ISO_CNT = ISO_SETUP[pwr_pkg::TIMER_W-1:0];

  pwr_pkg::pwr_state_e state_q;
  logic                sw_on_q;
  logic                iso_q;
  logic                dom_rst_n_q;
  logic                ret_q;
  logic                busy_q;
  logic                done_q;
  logic                tmr_load_q;
  logic                accept;

  // Legal moves out of the stable states
  function automatic logic cmd_legal(pwr_pkg::pwr_state_e st, pwr_pkg::pwr_cmd_e cmd);
    logic ok;
    ok = 1'b0;
    case (st)
      pwr_pkg::ST_OFF: ok = (cmd == pwr_pkg::CMD_ON);
      pwr_pkg::ST_ON:  ok = (cmd == pwr_pkg::CMD_OFF) || (cmd == pwr_pkg::CMD_RETAIN);
      pwr_pkg::ST_RET: ok = (cmd == pwr_pkg::CMD_ON) || (cmd == pwr_pkg::CMD_OFF);
      default:         ok = 1'b0;
    endcase
    return ok;
  endfunction

  assign accept = cmd_valid_i && !busy_q && cmd_legal(state_q, cmd_i);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q     <= pwr_pkg::ST_OFF;
      sw_on_q     <= 1'b0;
      iso_q       <= 1'b1;
      dom_rst_n_q <= 1'b0;
      ret_q       <= 1'b0;
      busy_q      <= 1'b0;
      done_q      <= 1'b0;
      tmr_load_q  <= 1'b0;
    end else begin
      tmr_load_q <= 1'b0;
      done_q     <= 1'b0;
      // Busy drops right after the done cycle
      if (done_q) begin
        busy_q <= 1'b0;
      end
      case (state_q)
        pwr_pkg::ST_OFF: begin
          if (accept) begin
            busy_q  <= 1'b1;
            sw_on_q <= 1'b1;
            state_q <= pwr_pkg::ST_UP_SW;
          end
        end
        pwr_pkg::ST_ON: begin
          if (accept) begin
            busy_q     <= 1'b1;
            iso_q      <= 1'b1;
            tmr_load_q <= 1'b1;
            if (cmd_i == pwr_pkg::CMD_RETAIN) begin
              state_q <= pwr_pkg::ST_RET_ENTER;
            end else begin
              state_q <= pwr_pkg::ST_DN_ISO;
            end
          end
        end
        pwr_pkg::ST_RET: begin
          if (accept) begin
            busy_q     <= 1'b1;
            ret_q      <= 1'b0;
            tmr_load_q <= 1'b1;
            // Isolation already up, so power-off joins at its reset step
            if (cmd_i == pwr_pkg::CMD_ON) begin
              state_q <= pwr_pkg::ST_RET_EXIT;
            end else begin
              state_q <= pwr_pkg::ST_DN_ISO;
            end
          end
        end
        pwr_pkg::ST_UP_SW: begin
          if (sw_ack_i) begin
            tmr_load_q <= 1'b1;
            state_q    <= pwr_pkg::ST_UP_RST;
          end
        end
        pwr_pkg::ST_UP_RST: begin
          // Reset released first, isolation one cycle later
          if (dom_rst_n_q) begin
            iso_q   <= 1'b0;
            done_q  <= 1'b1;
            state_q <= pwr_pkg::ST_ON;
          end else if (tmr_done_i) begin
            dom_rst_n_q <= 1'b1;
          end
        end
        pwr_pkg::ST_DN_ISO: begin
          if (tmr_done_i) begin
            dom_rst_n_q <= 1'b0;
            state_q     <= pwr_pkg::ST_DN_SW;
          end
        end
        pwr_pkg::ST_DN_SW: begin
          if (sw_on_q) begin
            sw_on_q <= 1'b0;
          end else if (!sw_ack_i) begin
            done_q  <= 1'b1;
            state_q <= pwr_pkg::ST_OFF;
          end
        end
        pwr_pkg::ST_RET_ENTER: begin
          if (tmr_done_i) begin
            ret_q   <= 1'b1;
            done_q  <= 1'b1;
            state_q <= pwr_pkg::ST_RET;
          end
        end
        pwr_pkg::ST_RET_EXIT: begin
          if (tmr_done_i) begin
            iso_q   <= 1'b0;
            done_q  <= 1'b1;
            state_q <= pwr_pkg::ST_ON;
          end
        end
        default: begin
          state_q <= pwr_pkg::ST_OFF;
        end
      endcase
    end
  end

  // Reset hold only during power-up, isolation setup everywhere else
  assign tmr_count_o = (state_q == pwr_pkg::ST_UP_RST) ? RST_CNT : ISO_CNT;
  assign tmr_load_o  = tmr_load_q;

  assign sw_on_o     = sw_on_q;
  assign iso_o       = iso_q;
  assign dom_rst_n_o = dom_rst_n_q;
  assign ret_o       = ret_q;
  assign busy_o      = busy_q;
  assign done_o      = done_q;
  assign state_o     = state_q;

endmodule

// File: verilog/pwr_switch_chain.sv
// Power switch cell model
// Daisy-chained switch cells: the acknowledge trails the switch command
// by ACK_LATENCY clock edges

`timescale 1ns/100ps

module pwr_switch_chain #(
  parameter int unsigned ACK_LATENCY = 15
) (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic sw_on_i,
  output logic sw_ack_o
);

  // One flop per switch cell
  logic [ACK_LATENCY-1:0] chain_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      chain_q <= '0;
    end else begin
      chain_q[0] <= sw_on_i;
      for (int i = 1; i < ACK_LATENCY; i++) begin
        chain_q[i] <= chain_q[i-1];
      end
    end
  end

  // Last cell in the chain reports back
  assign sw_ack_o = chain_q[ACK_LATENCY-1];

endmodule

// File: verilog/pwr_wait_timer.sv
// Wait timer for the power sequencer
// Loadable down-counter, idle at zero, one-cycle done on expiry

`timescale 1ns/100ps

module pwr_wait_timer (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  logic                        load_i,
  input  logic [pwr_pkg::TIMER_W-1:0] count_i,
  output logic                        done_o
);

  localparam logic [pwr_pkg::TIMER_W-1:0] CNT_LAST = 1;

  logic [pwr_pkg::TIMER_W-1:0] cnt_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      cnt_q <= '0;
    end else if (load_i) begin
      cnt_q <= count_i;
    end else if (cnt_q != '0) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  // Last cycle of the count, so a load of N ends N cycles later
  assign done_o = (cnt_q == CNT_LAST);

endmodule
